// File: sources.f
mipsPkg.sv
mipsDecode.sv
mipsRegFile.sv
mipsExecute.sv
mipsResult.sv
mipsCore.sv
mipsCoreAsserts.sv
mipsCoreTb.sv

// File: Makefile
BIN := obj_dir/VmipsCoreTb
SRCS := $(shell cat sources.f)

.PHONY: all run clean

all: run

$(BIN): $(SRCS) sources.f
	verilator --binary --timing --assert -f sources.f --top-module mipsCoreTb -Mdir obj_dir

run: $(BIN)
	@out="$$(./$(BIN) +verilator+error+limit+1000 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "^Simulation completed successfully$$"

clean:
	rm -rf obj_dir

// File: mipsCoreTb.sv
// testbench for the single-cycle MIPS core
// clock, reset, instruction ROM program
// Wishbone memory slave with random wait states
// ISA reference model checked at the falling edge
// watchdog and closing report

`timescale 1ns/1ps

bind mipsCore mipsCoreAsserts #(.DataAddrWidth(DataAddrWidth)) i_mipsCoreAsserts (
  .clk(clk), .rst(rst), .wbCyc(wbCyc), .wbStb(wbStb), .wbWe(wbWe), .wbAdr(wbAdr),
  .wbDatW(wbDatW), .wbAck(wbAck), .regWriteEn(regWriteEn), .regWriteAddr(regWriteAddr)
);

module mipsCoreTb;
  import mipsPkg::*;

  localparam int DataAddrWidth = 7;
  localparam int MemWords      = 1 << DataAddrWidth;
  localparam int ResetCycles   = 5;
  localparam int ProgLen       = 29;
  // final self loop of the program
  localparam logic [31:0] LoopPc = 32'd112;
  localparam int WatchdogNs    = (ProgLen * 5 + ResetCycles) * 100;

  logic                     clk;
  logic                     rst;
  logic [31:0]              instrAddr;
  logic [31:0]              instr;
  logic                     wbCyc;
  logic                     wbStb;
  logic                     wbWe;
  logic [DataAddrWidth-1:0] wbAdr;
  logic [31:0]              wbDatW;
  logic [31:0]              wbDatR;
  logic                     wbAck;
  logic                     regWriteEn;
  logic [4:0]               regWriteAddr;
  logic [31:0]              regWriteData;

  logic [31:0] rom [32];
  logic [31:0] slaveMem [MemWords];
  // reference model state
  logic [31:0] modelRegs [32];
  logic [31:0] modelMem [MemWords];
  logic [31:0] modelPc;
  logic        done;
  int          retired;
  int          errorCount;
  int          seed;
  int          waitLeft;
  logic        busy;
  // reset level seen by the core at the last rising edge
  logic        rstAtEdge;

  mipsCore #(.DataAddrWidth(DataAddrWidth)) i_mipsCore (
    .clk(clk), .rst(rst), .instrAddr(instrAddr), .instr(instr),
    .wbCyc(wbCyc), .wbStb(wbStb), .wbWe(wbWe), .wbAdr(wbAdr),
    .wbDatW(wbDatW), .wbDatR(wbDatR), .wbAck(wbAck),
    .regWriteEn(regWriteEn), .regWriteAddr(regWriteAddr), .regWriteData(regWriteData)
  );

  // combinational instruction port
  assign instr = rom[instrAddr[6:2]];

  // ==================================================
  // encoders and helpers
  // ==================================================
  function automatic logic [31:0] encodeR(input int rs, input int rt, input int rd,
                                          input logic [5:0] fn);
    return {opR, rs[4:0], rt[4:0], rd[4:0], 5'd0, fn};
  endfunction

  function automatic logic [31:0] encodeI(input logic [5:0] op, input int rs, input int rt,
                                          input int imm);
    return {op, rs[4:0], rt[4:0], imm[15:0]};
  endfunction

  function automatic logic [31:0] encodeJ(input logic [5:0] op, input int wordAddr);
    return {op, wordAddr[25:0]};
  endfunction

  // every word differs, sign bit varies
  function automatic logic [31:0] fillWord(input int addr);
    return 32'h9e3779b9 * (addr + 1);
  endfunction

  task automatic reportMismatch(input string testName, input logic [31:0] expected,
                                input logic [31:0] actual);
    errorCount++;
    $display("CHECK FAILED %s at pc %h: expected %h, actual %h",
             testName, modelPc, expected, actual);
  endtask

  task automatic loadProgram();
    for (int i = 0; i < 32; i++) begin
      rom[i] = 32'd0;
    end
    // operands from memory, two negative
    rom[0]  = encodeI(opLw, 0, 1, 0);
    rom[1]  = encodeI(opLw, 0, 2, 4);
    rom[2]  = encodeI(opLw, 0, 3, 8);
    rom[3]  = encodeR(1, 2, 4, fnAdd);
    rom[4]  = encodeR(1, 2, 5, fnSub);
    rom[5]  = encodeR(1, 3, 6, fnAnd);
    rom[6]  = encodeR(2, 3, 7, fnOr);
    // slt, negative against negative, then mixed signs
    rom[7]  = encodeR(1, 3, 8, fnSlt);
    rom[8]  = encodeR(2, 1, 9, fnSlt);
    rom[9]  = encodeR(1, 2, 10, fnSlt);
    // store then load of the same word, back to back
    rom[10] = encodeI(opSw, 0, 4, 16);
    rom[11] = encodeI(opLw, 0, 11, 16);
    rom[12] = encodeI(opSw, 0, 5, 20);
    // no write: dest 0, unknown opcode, unknown function
    rom[13] = encodeR(1, 2, 0, fnAdd);
    rom[14] = encodeI(6'h08, 0, 12, 5);
    rom[15] = encodeR(1, 2, 13, 6'h00);
    rom[16] = encodeR(0, 11, 12, fnAdd);
    // beq taken over two words
    rom[17] = encodeI(opBeq, 11, 4, 2);
    rom[18] = encodeR(1, 1, 13, fnAdd);
    rom[19] = encodeR(1, 1, 13, fnAdd);
    rom[20] = encodeI(opBeq, 1, 2, 5);
    rom[21] = encodeJ(opJal, 24);
    rom[22] = encodeR(2, 2, 13, fnAdd);
    rom[23] = encodeR(2, 2, 13, fnAdd);
    // link value through memory
    rom[24] = encodeI(opSw, 0, 31, 24);
    rom[25] = encodeI(opLw, 0, 14, 24);
    rom[26] = encodeJ(opJ, 28);
    rom[27] = encodeR(1, 2, 15, fnAdd);
    rom[28] = encodeI(opBeq, 0, 0, -1);
  endtask

  // ==================================================
  // reference model, one step per falling edge
  // ==================================================
  task automatic stepModel();
    logic [31:0] iw;
    logic [5:0]  op;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] imm;
    logic [31:0] addr;
    logic        isMem;
    logic        retire;
    logic        expEn;
    logic [4:0]  expAddr;
    logic [31:0] expData;
    logic [31:0] nextPc;
    iw      = rom[modelPc[6:2]];
    op      = iw[31:26];
    a       = modelRegs[iw[25:21]];
    b       = modelRegs[iw[20:16]];
    imm     = {{16{iw[15]}}, iw[15:0]};
    addr    = a + imm;
    isMem   = (op == opLw) || (op == opSw);
    // memory ops retire on the ack edge only
    retire  = !isMem || wbAck;
    expEn   = 1'b0;
    expAddr = iw[15:11];
    expData = 32'd0;
    nextPc  = modelPc + 32'd4;
    case (op)
      opR: begin
        expEn = 1'b1;
        case (iw[5:0])
          fnAdd: expData = a + b;
          fnSub: expData = a - b;
          fnAnd: expData = a & b;
          fnOr:  expData = a | b;
          fnSlt: expData = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
          default: expEn = 1'b0;
        endcase
      end
      opLw: begin
        expEn   = 1'b1;
        expAddr = iw[20:16];
        expData = modelMem[addr[DataAddrWidth+1:2]];
      end
      opBeq: begin
        if (a == b) begin
          nextPc = modelPc + 32'd4 + {imm[29:0], 2'b00};
        end
      end
      opJ: nextPc = {nextPc[31:28], iw[25:0], 2'b00};
      opJal: begin
        expEn   = 1'b1;
        expAddr = 5'd31;
        expData = modelPc + 32'd8;
        nextPc  = {nextPc[31:28], iw[25:0], 2'b00};
      end
      default: expEn = 1'b0;
    endcase
    expEn = expEn & retire & (expAddr != 5'd0);

    assert (instrAddr == modelPc)
      else reportMismatch("instruction address", modelPc, instrAddr);
    assert (wbCyc == isMem)
      else reportMismatch("bus cycle", 32'(isMem), 32'(wbCyc));
    if (isMem) begin
      assert (wbWe == (op == opSw))
        else reportMismatch("bus write enable", 32'(op == opSw), 32'(wbWe));
      assert (wbAdr == addr[DataAddrWidth+1:2])
        else reportMismatch("bus address", 32'(addr[DataAddrWidth+1:2]), 32'(wbAdr));
      if (op == opSw) begin
        assert (wbDatW == b)
          else reportMismatch("store data", b, wbDatW);
      end
    end
    assert (regWriteEn == expEn)
      else reportMismatch("write enable", 32'(expEn), 32'(regWriteEn));
    if (expEn) begin
      assert (regWriteAddr == expAddr)
        else reportMismatch("write address", 32'(expAddr), 32'(regWriteAddr));
      assert (regWriteData == expData)
        else reportMismatch("write data", expData, regWriteData);
    end

    if (retire) begin
      if (expEn) begin
        modelRegs[expAddr] = expData;
      end
      if (op == opSw) begin
        modelMem[addr[DataAddrWidth+1:2]] = b;
      end
      modelPc = nextPc;
      retired++;
      if (nextPc == LoopPc) begin
        done = 1'b1;
      end
    end
  endtask

  // ==================================================
  // clock, reset, main sequence
  // ==================================================
  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  initial begin
    rst        = 1'b0;
    wbAck      = 1'b0;
    wbDatR     = 32'd0;
    seed       = 32'hc94fa8be;
    busy       = 1'b0;
    rstAtEdge  = 1'b0;
    waitLeft   = 0;
    done       = 1'b0;
    retired    = 0;
    errorCount = 0;
    modelPc    = 32'd0;
    loadProgram();
    for (int i = 0; i < 32; i++) begin
      modelRegs[i] = 32'd0;
    end
    for (int i = 0; i < MemWords; i++) begin
      slaveMem[i] = fillWord(i);
      modelMem[i] = fillWord(i);
    end
    repeat (ResetCycles) @(posedge clk);
    #1 rst = 1'b1;
    wait (done);
    // a few turns of the final loop
    repeat (3) @(posedge clk);
    $display("checks failed: %0d, assertion failures: %0d, instructions retired: %0d",
             errorCount, i_mipsCore.i_mipsCoreAsserts.failCount, retired);
    if (errorCount == 0 && i_mipsCore.i_mipsCoreAsserts.failCount == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

  initial begin
    forever begin
      @(negedge clk);
      if (rst) begin
        stepModel();
      end
    end
  end

  // ==================================================
  // Wishbone slave, 0 to 3 wait cycles
  // ==================================================
  initial begin
    forever begin
      @(posedge clk);
      rstAtEdge = rst;
      #1;
      wbAck  = 1'b0;
      wbDatR = 32'd0;
      if (rstAtEdge && wbCyc && wbStb) begin
        // new transfer after an ack or an idle cycle
        if (!busy) begin
          waitLeft = $unsigned($random(seed)) % 4;
          busy     = 1'b1;
        end
        if (waitLeft == 0) begin
          wbAck  = 1'b1;
          wbDatR = slaveMem[wbAdr];
          if (wbWe) begin
            slaveMem[wbAdr] = wbDatW;
          end
          busy = 1'b0;
        end else begin
          waitLeft--;
        end
      end else begin
        busy = 1'b0;
      end
    end
  end

  // watchdog, five cycles per program word
  initial begin
    #(WatchdogNs);
    $display("watchdog expired: core stopped retiring after %0d instructions", retired);
    $display("Simulation failed");
    $finish;
  end

endmodule

// File: mipsCoreAsserts.sv
// concurrent checks bound into the MIPS core
// Wishbone classic master rules under wait states
// write-back never targets register 0
// bus and write enable quiet during reset

`timescale 1ns/1ps

module mipsCoreAsserts #(
  parameter int DataAddrWidth = 7
) (
  input logic                     clk,
  input logic                     rst,
  input logic                     wbCyc,
  input logic                     wbStb,
  input logic                     wbWe,
  input logic [DataAddrWidth-1:0] wbAdr,
  input logic [31:0]              wbDatW,
  input logic                     wbAck,
  input logic                     regWriteEn,
  input logic [4:0]               regWriteAddr
);

  // failures seen so far, read by the testbench
  int failCount = 0;

  // ==================================================
  // Wishbone master
  // ==================================================
  stbNeedsCyc: assert property (@(posedge clk) wbStb |-> wbCyc)
    else begin
      failCount++;
      $error("stb high without cyc");
    end

  // request held until the slave acks
  requestHeld: assert property (@(posedge clk) disable iff (!rst)
    (wbStb && !wbAck) |=> (wbStb && $stable(wbAdr) && $stable(wbWe) && $stable(wbDatW)))
    else begin
      failCount++;
      $error("request changed before ack");
    end

  // ==================================================
  // write-back and reset
  // ==================================================
  noZeroWrite: assert property (@(posedge clk) regWriteEn |-> (regWriteAddr != 5'd0))
    else begin
      failCount++;
      $error("register write to address 0");
    end

  quietInReset: assert property (@(posedge clk) !rst |-> (!wbCyc && !wbStb && !regWriteEn))
    else begin
      failCount++;
      $error("bus or write enable active in reset");
    end

endmodule

// File: mipsCore.sv
// top level of the single-cycle MIPS core
// decode, register file, execute and result wired together

`timescale 1ns/1ps

module mipsCore #(
  parameter int DataAddrWidth = 7
) (
  input  logic                     clk,
  input  logic                     rst,
  output logic [31:0]              instrAddr,
  input  logic [31:0]              instr,
  output logic                     wbCyc,
  output logic                     wbStb,
  output logic                     wbWe,
  output logic [DataAddrWidth-1:0] wbAdr,
  output logic [31:0]              wbDatW,
  input  logic [31:0]              wbDatR,
  input  logic                     wbAck,
  output logic                     regWriteEn,
  output logic [4:0]               regWriteAddr,
  output logic [31:0]              regWriteData
);
  import mipsPkg::*;

  // decode outputs
  logic [4:0]  rsIdx;
  logic [4:0]  rtIdx;
  logic [4:0]  rdIdx;
  logic [31:0] immExt;
  logic [25:0] jumpTarget;
  aluOpT       aluOp;
  logic        aluSrcImm;
  logic        isBranch;
  logic        isJump;
  logic        memRead;
  logic        memWrite;
  logic        regWrite;
  wbSrcT       wbSrc;
  // register file and execute outputs
  logic [31:0] readData1;
  logic [31:0] readData2;
  logic [31:0] aluResult;
  logic        takeBranch;

  mipsDecode i_mipsDecode (
    .instr(instr), .rsIdx(rsIdx), .rtIdx(rtIdx), .rdIdx(rdIdx),
    .immExt(immExt), .jumpTarget(jumpTarget), .aluOp(aluOp),
    .aluSrcImm(aluSrcImm), .isBranch(isBranch), .isJump(isJump),
    .memRead(memRead), .memWrite(memWrite), .regWrite(regWrite), .wbSrc(wbSrc)
  );

  // write port driven by the result stage
  mipsRegFile i_mipsRegFile (
    .clk(clk), .rst(rst), .rsIdx(rsIdx), .rtIdx(rtIdx),
    .readData1(readData1), .readData2(readData2),
    .writeEn(regWriteEn), .writeAddr(regWriteAddr), .writeData(regWriteData)
  );

  mipsExecute i_mipsExecute (
    .readData1(readData1), .readData2(readData2), .immExt(immExt),
    .aluSrcImm(aluSrcImm), .aluOp(aluOp), .isBranch(isBranch),
    .aluResult(aluResult), .takeBranch(takeBranch)
  );

  // rt value doubles as store data
  mipsResult #(.DataAddrWidth(DataAddrWidth)) i_mipsResult (
    .clk(clk), .rst(rst), .aluResult(aluResult), .storeData(readData2),
    .immExt(immExt), .jumpTarget(jumpTarget), .takeBranch(takeBranch),
    .isJump(isJump), .memRead(memRead), .memWrite(memWrite),
    .regWrite(regWrite), .destIdx(rdIdx), .wbSrc(wbSrc), .pc(instrAddr),
    .wbCyc(wbCyc), .wbStb(wbStb), .wbWe(wbWe), .wbAdr(wbAdr),
    .wbDatW(wbDatW), .wbDatR(wbDatR), .wbAck(wbAck),
    .regWriteEn(regWriteEn), .regWriteAddr(regWriteAddr),
    .regWriteData(regWriteData)
  );

endmodule

// File: mipsResult.sv
// result stage of the single-cycle MIPS core
// PC register and next-PC select
// Wishbone classic data master with stall on missing ack
// register write qualification and write-back mux

`timescale 1ns/1ps

module mipsResult #(
  parameter int DataAddrWidth = 7
) (
  input  logic                     clk,
  input  logic                     rst,
  input  logic [31:0]              aluResult,
  input  logic [31:0]              storeData,
  input  logic [31:0]              immExt,
  input  logic [25:0]              jumpTarget,
  input  logic                     takeBranch,
  input  logic                     isJump,
  input  logic                     memRead,
  input  logic                     memWrite,
  input  logic                     regWrite,
  input  logic [4:0]               destIdx,
  input  mipsPkg::wbSrcT           wbSrc,
  output logic [31:0]              pc,
  output logic                     wbCyc,
  output logic                     wbStb,
  output logic                     wbWe,
  output logic [DataAddrWidth-1:0] wbAdr,
  output logic [31:0]              wbDatW,
  input  logic [31:0]              wbDatR,
  input  logic                     wbAck,
  output logic                     regWriteEn,
  output logic [4:0]               regWriteAddr,
  output logic [31:0]              regWriteData
);
  import mipsPkg::*;

  logic        memAccess;
  logic        stall;
  logic [31:0] pcPlus4;
  logic [31:0] pcPlus8;
  logic [31:0] branchAddr;
  logic [31:0] jumpAddr;
  logic [31:0] pcNext;

  // ==================================================
  // Wishbone master
  // ==================================================
  assign memAccess = memRead | memWrite;
  // hold everything until the slave acks
  assign stall     = memAccess & ~wbAck;
  // cyc and stb rise together, low in reset
  assign wbCyc  = memAccess & rst;
  assign wbStb  = memAccess & rst;
  assign wbWe   = memWrite & rst;
  // word address from byte address
  assign wbAdr  = aluResult[DataAddrWidth+1:2];
  assign wbDatW = storeData;

  // ==================================================
  // next PC
  // ==================================================
  assign pcPlus4    = pc + 32'd4;
  assign pcPlus8    = pc + 32'd8;
  // offset counts words
  assign branchAddr = pcPlus4 + {immExt[29:0], 2'b00};
  assign jumpAddr   = {pcPlus4[31:28], jumpTarget, 2'b00};

  always_comb begin
    if (stall) begin
      pcNext = pc;
    end else if (isJump) begin
      pcNext = jumpAddr;
    end else if (takeBranch) begin
      pcNext = branchAddr;
    end else begin
      pcNext = pcPlus4;
    end
  end

  always_ff @(posedge clk or negedge rst) begin
    if (!rst) begin
      pc <= 32'd0;
    end else begin
      pc <= pcNext;
    end
  end

  // ==================================================
  // write-back
  // ==================================================
  // lw writes only on its ack cycle, never to $zero
  assign regWriteEn   = regWrite & ~stall & rst & (destIdx != 5'd0);
  assign regWriteAddr = destIdx;

  always_comb begin
    case (wbSrc)
      wbMem:   regWriteData = wbDatR;
      // jal return address
      wbLink:  regWriteData = pcPlus8;
      default: regWriteData = aluResult;
    endcase
  end

endmodule

// File: mipsExecute.sv
// execute stage of the single-cycle MIPS core
// second operand select, ALU, beq condition

`timescale 1ns/1ps

module mipsExecute (
  input  logic [31:0]    readData1,
  input  logic [31:0]    readData2,
  input  logic [31:0]    immExt,
  input  logic           aluSrcImm,
  input  mipsPkg::aluOpT aluOp,
  input  logic           isBranch,
  output logic [31:0]    aluResult,
  output logic           takeBranch
);
  import mipsPkg::*;

  logic [31:0] opA;
  logic [31:0] opB;
  logic        opEqual;

  // ==================================================
  // operands
  // ==================================================
  assign opA = readData1;
  // offset for lw/sw, rt otherwise
  assign opB = aluSrcImm ? immExt : readData2;

  // ==================================================
  // ALU
  // ==================================================
  always_comb begin
    case (aluOp)
      aluAdd: aluResult = opA + opB;
      aluSub: aluResult = opA - opB;
      aluAnd: aluResult = opA & opB;
      aluOr:  aluResult = opA | opB;
      // signed less-than, result is 0 or 1
      aluSlt: aluResult = ($signed(opA) < $signed(opB)) ? 32'd1 : 32'd0;
      default: aluResult = 32'd0;
    endcase
  end

  // ==================================================
  // branch condition
  // ==================================================
  // beq uses rt as second operand
  assign opEqual    = (opA == opB);
  assign takeBranch = isBranch & opEqual;

endmodule

// File: mipsRegFile.sv
// 32 x 32-bit register file
// two combinational read ports, one synchronous write port
// register 0 always reads as zero

`timescale 1ns/1ps

module mipsRegFile (
  input  logic        clk,
  input  logic        rst,
  input  logic [4:0]  rsIdx,
  input  logic [4:0]  rtIdx,
  output logic [31:0] readData1,
  output logic [31:0] readData2,
  input  logic        writeEn,
  input  logic [4:0]  writeAddr,
  input  logic [31:0] writeData
);

  logic [31:0] regs [32];

  // ==================================================
  // write port
  // ==================================================
  // whole array cleared while rst is low
  always_ff @(posedge clk or negedge rst) begin
    if (!rst) begin
      for (int i = 0; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (writeEn) begin
      // dest 0 already filtered upstream
      regs[writeAddr] <= writeData;
    end
  end

  // ==================================================
  // read ports
  // ==================================================
  // $zero forced on read
  assign readData1 = (rsIdx == 5'd0) ? 32'd0 : regs[rsIdx];
  assign readData2 = (rtIdx == 5'd0) ? 32'd0 : regs[rtIdx];

endmodule

// File: mipsDecode.sv
// instruction decode for the single-cycle MIPS core
// field split, offset sign extension, destination select
// merged main and ALU control table

`timescale 1ns/1ps

module mipsDecode (
  input  logic [31:0]          instr,
  output logic [4:0]           rsIdx,
  output logic [4:0]           rtIdx,
  output logic [4:0]           rdIdx,
  output logic [31:0]          immExt,
  output logic [25:0]          jumpTarget,
  output mipsPkg::aluOpT       aluOp,
  output logic                 aluSrcImm,
  output logic                 isBranch,
  output logic                 isJump,
  output logic                 memRead,
  output logic                 memWrite,
  output logic                 regWrite,
  output mipsPkg::wbSrcT       wbSrc
);
  import mipsPkg::*;

  logic [5:0] opcode;
  logic [5:0] funct;

  // ==================================================
  // field split
  // ==================================================
  assign opcode     = instr[31:26];
  assign funct      = instr[5:0];
  assign rsIdx      = instr[25:21];
  assign rtIdx      = instr[20:16];
  assign jumpTarget = instr[25:0];
  // 16-bit offset, sign extended
  assign immExt     = {{16{instr[15]}}, instr[15:0]};

  // ==================================================
  // control table
  // ==================================================
  always_comb begin
    // defaults retire as a no-op
    aluOp     = aluAdd;
    aluSrcImm = 1'b0;
    isBranch  = 1'b0;
    isJump    = 1'b0;
    memRead   = 1'b0;
    memWrite  = 1'b0;
    regWrite  = 1'b0;
    wbSrc     = wbAlu;
    // rd unless overridden below
    rdIdx     = instr[15:11];
    case (opcode)
      opR: begin
        // only known function codes write
        case (funct)
          fnAdd: begin aluOp = aluAdd; regWrite = 1'b1; end
          fnSub: begin aluOp = aluSub; regWrite = 1'b1; end
          fnAnd: begin aluOp = aluAnd; regWrite = 1'b1; end
          fnOr:  begin aluOp = aluOr;  regWrite = 1'b1; end
          fnSlt: begin aluOp = aluSlt; regWrite = 1'b1; end
          default: regWrite = 1'b0;
        endcase
      end
      opLw: begin
        aluSrcImm = 1'b1;
        memRead   = 1'b1;
        regWrite  = 1'b1;
        wbSrc     = wbMem;
        rdIdx     = instr[20:16];
      end
      opSw: begin
        aluSrcImm = 1'b1;
        memWrite  = 1'b1;
      end
      opBeq: begin
        // compare by subtraction
        aluOp    = aluSub;
        isBranch = 1'b1;
      end
      opJ: isJump = 1'b1;
      opJal: begin
        isJump   = 1'b1;
        regWrite = 1'b1;
        wbSrc    = wbLink;
        rdIdx    = linkReg;
      end
      default: regWrite = 1'b0;
    endcase
  end

endmodule

// File: mipsPkg.sv
// shared encodings for the single-cycle MIPS core
// opcode and function-code constants
// ALU operation and write-back source enums
// link register index used by jal

package mipsPkg;

  // ==================================================
  // opcodes, instr[31:26]
  // ==================================================
  // R-type, function code selects the operation
  localparam logic [5:0] opR   = 6'b000000;
  // memory access, base plus offset
  localparam logic [5:0] opLw  = 6'b100011;
  localparam logic [5:0] opSw  = 6'b101011;
  // branch and jumps
  localparam logic [5:0] opBeq = 6'b000100;
  localparam logic [5:0] opJ   = 6'b000010;
  localparam logic [5:0] opJal = 6'b000011;

  // ==================================================
  // function codes, instr[5:0] of R-type
  // ==================================================
  localparam logic [5:0] fnAdd = 6'b100000;
  localparam logic [5:0] fnSub = 6'b100010;
  localparam logic [5:0] fnAnd = 6'b100100;
  localparam logic [5:0] fnOr  = 6'b100101;
  // signed compare
  localparam logic [5:0] fnSlt = 6'b101010;

  // ==================================================
  // control-word fields
  // ==================================================
  // ALU operation, one code per supported op
  typedef enum logic [2:0] {
    aluAdd = 3'd0,
    aluSub = 3'd1,
    aluAnd = 3'd2,
    aluOr  = 3'd3,
    aluSlt = 3'd4
  } aluOpT;

  // where the register write data comes from
  typedef enum logic [1:0] {
    wbAlu  = 2'd0,
    wbMem  = 2'd1,
    // return address for jal
    wbLink = 2'd2
  } wbSrcT;

  // jal destination, $ra
  localparam logic [4:0] linkReg = 5'd31;

endpackage
